//--- project.f
+incdir+.
stepper_pkg.sv
fx_mult.sv
tick_divider.sv
step_profile.sv
stepper_axis_top.sv
tb_stepper_axis.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the stepper axis simulation with Verilator

rm -f sim.log build.log

verilator --binary --timing -f project.f --top-module tb_stepper_axis \
  -o sim_stepper > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/sim_stepper > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q "Something failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log || { echo "No pass message in log"; exit 1; }
echo "Simulation PASSED"
exit 0

//--- tb_stepper_axis.sv
`timescale 1ns/1ps
`include "stepper_params.svh"

module tb_stepper_axis;

  localparam int NUM_RANDOM = 12;
  localparam longint TRISE = `STEP_TRISE;
  localparam longint SLOW = `STEP_VRISE + `STEP_VOFFSET;

  logic                      clk_i;
  logic                      rst_n_i;
  stepper_pkg::move_cmd_t    cmd_i;
  logic                      step_o;
  stepper_pkg::axis_status_t status_o;

  // Model state
  string  cur_test = "reset";
  longint target = 0;
  longint ecount = -1;
  longint en_edges = 0;
  longint m_t = 1;
  logic   m_cb = 1'b0;
  logic   cb_pend = 1'b0;
  logic   m_run = 1'b0;
  longint pulses = 0;
  longint last_step = 0;
  longint gap;
  longint prev_gap = 0;
  longint exp_gap = 0;
  logic   exp_mode = 1'b0;
  logic   prev_mode = 1'b0;
  longint hist1 = 0;
  longint hist2 = 0;
  logic   cbh1 = 1'b0;
  logic   cbh2 = 1'b0;
  logic   rst_prev = 1'b0;
  logic   en_prev = 1'b0;
  longint budget = 0;
  stepper_pkg::fix_t angles [NUM_RANDOM];

  stepper_axis_top i_stepper_axis_top (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cmd_i    (cmd_i),
    .step_o   (step_o),
    .status_o (status_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_count(input string name, input stepper_pkg::fix_t exp_v,
                             input stepper_pkg::fix_t act_v);
    if (exp_v !== act_v)
      fail_now($sformatf("[FAIL] %s step count expected %0d actual %0d", name, exp_v, act_v));
  endtask

  task automatic check_status(input string name, input stepper_pkg::axis_status_t exp_v,
                              input stepper_pkg::axis_status_t act_v);
    if (exp_v !== act_v)
      fail_now($sformatf("[FAIL] %s status expected %b actual %b", name, exp_v, act_v));
  endtask

  task automatic check_period(input string name, input stepper_pkg::period_t exp_v,
                              input stepper_pkg::period_t act_v);
    if (exp_v !== act_v)
      fail_now($sformatf("[FAIL] %s step gap expected %0d actual %0d", name, exp_v, act_v));
  endtask

  // Step period from the ramp rule for elapsed time t
  function automatic longint period_of(input longint t);
    longint ramp;
    if (t >= 1 && t < TRISE) ramp = `STEP_SPEEDUP * t;
    else ramp = `STEP_VRISE;
    return `STEP_VRISE - ramp + `STEP_VOFFSET;
  endfunction

  // Integer part of the magnitude times the gearing factor
  function automatic longint expected_steps(input stepper_pkg::fix_t mag);
    logic [127:0] prod;
    prod = 128'(mag) * 128'(`STEP_SCALE);
    return longint'(prod >> `STEP_QBITS);
  endfunction

  // Cycle model of the profile sampled after each rising edge
  always @(negedge clk_i) begin
    if (rst_prev) begin
      ecount = ecount + 1;
      if (m_run && (ecount % `STEP_US_CYCLES == 1)) begin
        if (m_cb) begin
          if (m_t > 1) m_t = m_t - 1;
        end else if (m_t < TRISE) begin
          m_t = m_t + 1;
        end
      end
      m_cb = m_cb | cb_pend;
      cb_pend = 1'b0;
      en_edges = en_prev ? en_edges + 1 : 0;
      if (en_edges == 1) begin
        // Fresh move from the slow end of the ramp
        m_t = 1;
        m_cb = 1'b0;
        pulses = 0;
        last_step = ecount;
        exp_gap = period_of(1) + 2;
        exp_mode = 1'b0;
      end
      if (step_o) begin
        if (!m_run) fail_now($sformatf("Step pulse outside an active move in %s", cur_test));
        gap = ecount - last_step;
        check_period(cur_test, exp_gap, gap);
        if (pulses > 0) begin
          if (gap < `STEP_VOFFSET || gap > SLOW)
            fail_now($sformatf("Step gap %0d out of range in %s", gap, cur_test));
          if (!prev_mode && !exp_mode && gap > prev_gap)
            fail_now($sformatf("Step gap grew while accelerating in %s", cur_test));
          if (prev_mode && exp_mode && gap < prev_gap)
            fail_now($sformatf("Step gap shrank while decelerating in %s", cur_test));
        end
        prev_gap = gap;
        prev_mode = exp_mode;
        // Divider loaded its next period one edge before this pulse
        exp_gap = hist2;
        exp_mode = cbh2;
        pulses = pulses + 1;
        if (m_t >= TRISE && pulses >= (target >> 1)) cb_pend = 1'b1;
        last_step = ecount;
      end
      m_run = (en_edges >= 2) && (pulses < target);
    end
    hist2 = hist1;
    hist1 = period_of(m_t);
    cbh2 = cbh1;
    cbh1 = m_cb;
    rst_prev = rst_n_i;
    en_prev = cmd_i.enable;
  end

  task automatic run_move(input string name, input stepper_pkg::fix_t angle);
    stepper_pkg::fix_t mag;
    logic neg;
    neg = angle[`STEP_SIZE-1];
    mag = neg ? -angle : angle;
    cur_test = name;
    target = expected_steps(mag);
    @(posedge clk_i);
    cmd_i.angle <= angle;
    cmd_i.enable <= 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_status(name, '{busy: 1'b0, done: 1'b0, overflow: 1'b0, dir: neg}, status_o);
    @(negedge clk_i);
    if (target != 0)
      check_status(name, '{busy: 1'b1, done: 1'b0, overflow: 1'b0, dir: neg}, status_o);
    while (!status_o.done) begin
      if (!status_o.busy) fail_now($sformatf("Busy dropped before done in %s", name));
      @(negedge clk_i);
    end
    check_count(name, stepper_pkg::fix_t'(target), stepper_pkg::fix_t'(pulses));
    check_status(name, '{busy: 1'b0, done: 1'b1, overflow: 1'b0, dir: neg}, status_o);
    @(posedge clk_i);
    cmd_i.enable <= 1'b0;
    @(negedge clk_i);
    @(negedge clk_i);
    check_status(name, '{busy: 1'b0, done: 1'b0, overflow: 1'b0, dir: neg}, status_o);
  endtask

  // Abort partway and rerun the same move from the slowest period
  task automatic abort_move(input stepper_pkg::fix_t angle);
    cur_test = "abort";
    target = expected_steps(angle);
    @(posedge clk_i);
    cmd_i.angle <= angle;
    cmd_i.enable <= 1'b1;
    while (pulses < 5 || en_edges < 2) @(negedge clk_i);
    @(posedge clk_i);
    cmd_i.enable <= 1'b0;
    @(negedge clk_i);
    @(negedge clk_i);
    if (step_o !== 1'b0) fail_now("Step pulse after enable dropped in abort");
    check_status("abort", '{busy: 1'b0, done: 1'b0, overflow: 1'b0, dir: 1'b0}, status_o);
    // Monitor flags any pulse while no move runs
    repeat (3000) @(negedge clk_i);
    run_move("abort_restart", angle);
  endtask

  task automatic overflow_move(input stepper_pkg::fix_t angle);
    cur_test = "overflow";
    target = 0;
    @(posedge clk_i);
    cmd_i.angle <= angle;
    cmd_i.enable <= 1'b1;
    repeat (3) @(negedge clk_i);
    check_status("overflow", '{busy: 1'b0, done: 1'b0, overflow: 1'b1, dir: 1'b0}, status_o);
    repeat (200) @(negedge clk_i);
    @(posedge clk_i);
    cmd_i.enable <= 1'b0;
    repeat (2) @(negedge clk_i);
    check_status("overflow", '{busy: 1'b0, done: 1'b0, overflow: 1'b0, dir: 1'b0}, status_o);
  endtask

  // Watchdog sized from the slow period of every planned step
  initial begin
    wait (budget != 0);
    repeat (budget) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Something failed");
    $fatal(1);
  end

  initial begin
    longint total;
    longint mag;
    stepper_pkg::fix_t small_angle;
    cmd_i = '0;
    rst_n_i = 1'b0;
    void'($urandom(42));
    total = 0;
    // Up to about 40 microsteps per random move
    for (int i = 0; i < NUM_RANDOM; i++) begin
      mag = longint'($urandom_range(0, 32'd41871488));
      angles[i] = stepper_pkg::fix_t'(mag);
      if ($urandom & 1) angles[i] = -angles[i];
      total = total + expected_steps(stepper_pkg::fix_t'(mag));
    end
    small_angle = stepper_pkg::fix_t'(64'd20000000);
    total = total + 2 * expected_steps(small_angle);
    budget = total * (SLOW + 4) + 40 * 5000;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) @(negedge clk_i);
    if (step_o !== 1'b0) fail_now("Step output high after reset");
    check_status("reset", '0, status_o);
    for (int i = 0; i < NUM_RANDOM; i++) run_move($sformatf("random_%0d", i), angles[i]);
    abort_move(small_angle);
    overflow_move(stepper_pkg::fix_t'(64'h0100_0000_0000_0000));
    run_move("zero_angle", '0);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- stepper_axis_top.sv
`timescale 1ns/1ps
`include "stepper_params.svh"

module stepper_axis_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  stepper_pkg::move_cmd_t    cmd_i,
  output logic                      step_o,
  output stepper_pkg::axis_status_t status_o
);

  // Gearing scale factor in Q32.32
  localparam stepper_pkg::fix_t SCALE_FX = stepper_pkg::fix_t'(`STEP_SCALE) << `STEP_QBITS;
  // Microsecond tick period in clk_i cycles
  localparam logic [31:0] US_PERIOD = `STEP_US_CYCLES;

  stepper_pkg::fix_t    angle_mag;
  logic                 angle_neg;
  stepper_pkg::fix_t    steps_needed;
  logic                 mult_ovf;
  logic                 us_tick;
  logic                 step_tick;
  logic                 div_clear;
  stepper_pkg::period_t period_cyc;

  // Sign gives the direction, magnitude feeds the multiplier
  assign angle_neg = cmd_i.angle[`STEP_SIZE-1];
  assign angle_mag = angle_neg ? -cmd_i.angle : cmd_i.angle;

  // Angle to microsteps
  fx_mult i_fx_mult (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .multiplicand_i (angle_mag),
    .multiplier_i   (SCALE_FX),
    .result_o       (steps_needed),
    .overflow_o     (mult_ovf)
  );

  // Free-running microsecond time base
  tick_divider #(
    .cnt_t (logic [31:0])
  ) i_us_divider (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (1'b0),
    .period_i (US_PERIOD),
    .tick_o   (us_tick)
  );

  // Step rate divider, period set by the profile
  tick_divider #(
    .cnt_t (stepper_pkg::period_t)
  ) i_step_divider (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (div_clear),
    .period_i (period_cyc),
    .tick_o   (step_tick)
  );

  step_profile i_step_profile (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enable_i       (cmd_i.enable),
    .dir_i          (angle_neg),
    .steps_needed_i (steps_needed),
    .mult_ovf_i     (mult_ovf),
    .us_tick_i      (us_tick),
    .step_tick_i    (step_tick),
    .period_o       (period_cyc),
    .div_clear_o    (div_clear),
    .step_o         (step_o),
    .status_o       (status_o)
  );

endmodule

//--- step_profile.sv
`timescale 1ns/1ps
`include "stepper_params.svh"

module step_profile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      enable_i,
  input  logic                      dir_i,
  input  stepper_pkg::fix_t         steps_needed_i,
  input  logic                      mult_ovf_i,
  input  logic                      us_tick_i,
  input  logic                      step_tick_i,
  output stepper_pkg::period_t      period_o,
  output logic                      div_clear_o,
  output logic                      step_o,
  output stepper_pkg::axis_status_t status_o
);

  localparam stepper_pkg::period_t ONE     = 1;
  localparam stepper_pkg::period_t TRISE   = `STEP_TRISE;
  localparam stepper_pkg::period_t VRISE   = `STEP_VRISE;
  localparam stepper_pkg::period_t VOFFSET = `STEP_VOFFSET;
  localparam stepper_pkg::period_t SPEEDUP = `STEP_SPEEDUP;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RUN,
    ST_DONE
  } state_t;

  state_t                    state_q;
  stepper_pkg::axis_status_t status_q;
  // Elapsed time in microsecond ticks, kept within 1 to TRISE
  stepper_pkg::period_t      t_q;
  // Deceleration phase
  logic                      count_back_q;
  stepper_pkg::period_t      steps_done_q;
  stepper_pkg::period_t      target_q;
  stepper_pkg::period_t      steps_next;
  stepper_pkg::period_t      steps_int;
  stepper_pkg::period_t      ramp;
  logic                      step_q;

  // Whole microsteps of the scaled angle
  assign steps_int = stepper_pkg::period_t'(steps_needed_i[`STEP_SIZE-1:`STEP_QBITS]);

  assign steps_next = steps_done_q + ONE;

  // Linear ramp inside the window and full span once past it
  always_comb begin
    if (t_q >= ONE && t_q < TRISE) begin
      ramp = SPEEDUP * t_q;
    end else begin
      ramp = VRISE;
    end
  end

  // Long period at the start and VOFFSET at full speed
  assign period_o = VRISE - ramp + VOFFSET;

  // Step divider only counts during an active run
  assign div_clear_o = (state_q != ST_RUN) || !enable_i;

  assign step_o   = step_q;
  assign status_o = status_q;

  // One-cycle step pulse taken from the divider tick
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      step_q <= 1'b0;
    end else begin
      step_q <= step_tick_i && enable_i && (state_q == ST_RUN);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      status_q     <= '0;
      t_q          <= ONE;
      count_back_q <= 1'b0;
      steps_done_q <= '0;
      target_q     <= '0;
    end else if (!enable_i) begin
      // Abort or release after the move keeps the direction
      state_q           <= ST_IDLE;
      status_q.busy     <= 1'b0;
      status_q.done     <= 1'b0;
      status_q.overflow <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // New move starts the profile from the slow end
          status_q.dir <= dir_i;
          t_q          <= ONE;
          count_back_q <= 1'b0;
          steps_done_q <= '0;
          state_q      <= ST_WAIT;
        end
        ST_WAIT: begin
          // Product is ready one cycle after the command
          target_q <= steps_int;
          if (mult_ovf_i || steps_needed_i[`STEP_SIZE-1]) begin
            status_q.overflow <= 1'b1;
            state_q           <= ST_DONE;
          end else if (steps_int == '0) begin
            // Nothing to move
            status_q.done <= 1'b1;
            state_q       <= ST_DONE;
          end else begin
            status_q.busy <= 1'b1;
            state_q       <= ST_RUN;
          end
        end
        ST_RUN: begin
          // Time runs up while accelerating and back down toward 1 after
          if (us_tick_i) begin
            if (count_back_q) begin
              if (t_q > ONE) begin
                t_q <= t_q - ONE;
              end
            end else if (t_q < TRISE) begin
              t_q <= t_q + ONE;
            end
          end
          if (step_q) begin
            steps_done_q <= steps_next;
            // Mirror the ramp once half way and at full speed
            if (t_q >= TRISE && steps_next >= (target_q >> 1)) begin
              count_back_q <= 1'b1;
            end
            if (steps_next == target_q) begin
              status_q.busy <= 1'b0;
              status_q.done <= 1'b1;
              state_q       <= ST_DONE;
            end
          end
        end
        ST_DONE: begin
          // Hold until enable falls
          state_q <= ST_DONE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Pulses stay off for two edges after enable drops, even on a quick restart
  a_step_needs_enable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!$past(enable_i) || !$past(enable_i, 2)) |-> !step_o
  );

  // Run never steps past the latched target
  a_steps_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    steps_done_q <= target_q
  );

endmodule

//--- tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
  parameter type cnt_t = logic [31:0]
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clear_i,
  input  cnt_t period_i,
  output logic tick_o
);

  // Running count within one period
  cnt_t cnt_q;
  // Period taken at the last wrap or clear
  cnt_t period_q;
  logic wrap;

  // Last count of the period
  assign wrap = (cnt_q + cnt_t'(1)) >= period_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      period_q <= '0;
      tick_o   <= 1'b0;
    end else if (clear_i) begin
      // Hold at zero and keep tracking the requested period
      cnt_q    <= '0;
      period_q <= period_i;
      tick_o   <= 1'b0;
    end else if (wrap) begin
      cnt_q    <= '0;
      // New period applies from this wrap on
      period_q <= period_i;
      tick_o   <= 1'b1;
    end else begin
      cnt_q  <= cnt_q + cnt_t'(1);
      tick_o <= 1'b0;
    end
  end

  // Back-to-back ticks only happen for periods below two
  a_tick_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (tick_o && ($past(period_i) >= cnt_t'(2))) |=> !tick_o
  );

endmodule

//--- fx_mult.sv
`timescale 1ns/1ps
`include "stepper_params.svh"

module fx_mult (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  stepper_pkg::fix_t multiplicand_i,
  input  stepper_pkg::fix_t multiplier_i,
  output stepper_pkg::fix_t result_o,
  output logic              overflow_o
);

  localparam int N = `STEP_SIZE;
  localparam int Q = `STEP_QBITS;

  // Full double-width signed product
  logic signed [2*N-1:0] product;
  // Dropped upper bits together with the sign bit of the kept window
  logic [N-Q:0] high_bits;
  logic         ovf_next;

  // Both operands sign extended to the full product width
  assign product = (2*N)'(multiplicand_i) * (2*N)'(multiplier_i);

  assign high_bits = product[2*N-1:N+Q-1];

  // Fits only when the dropped bits all repeat the sign
  assign ovf_next = !((&high_bits) || !(|high_bits));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o   <= '0;
      overflow_o <= 1'b0;
    end else begin
      // Q-aligned middle window of the product
      result_o   <= product[N+Q-1:Q];
      overflow_o <= ovf_next;
    end
  end

  // Product register stays known once out of reset
  a_result_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(result_o)
  );

endmodule

//--- stepper_pkg.sv
`include "stepper_params.svh"

package stepper_pkg;

  // Signed Q32.32 word
  // Holds either an angle or a scaled step count
  typedef logic signed [`STEP_SIZE-1:0] fix_t;

  // Unsigned count of clk_i cycles
  typedef logic [`STEP_SIZE-1:0] period_t;

  // Move request
  // The enable level starts the move and aborts it when dropped
  typedef struct packed {
    logic enable;
    // Relative angle, negative turns the other way
    fix_t angle;
  } move_cmd_t;

  // Axis state as seen from outside
  typedef struct packed {
    // Move in progress
    logic busy;
    // Target reached, held while enable stays high
    logic done;
    // Scaled count did not fit and the move was refused
    logic overflow;
    // High for a negative angle
    logic dir;
  } axis_status_t;

endpackage

//--- stepper_params.svh
`ifndef STEPPER_PARAMS_SVH
`define STEPPER_PARAMS_SVH

// Fixed-point word width
`define STEP_SIZE 64
// Fraction bits of the Q32.32 format
`define STEP_QBITS 32

// Microsteps per unit angle after gearing, integer part
`define STEP_SCALE 4103

// System clock in Hz
`define STEP_SYSCLK 25000000
// clk_i cycles per microsecond tick
`define STEP_US_CYCLES (`STEP_SYSCLK / 1000000)

// Span of the step period ramp in clk_i cycles
`define STEP_VRISE 2000
// Length of the ramp in microsecond ticks
`define STEP_TRISE 1000
// Shortest step period in clk_i cycles
`define STEP_VOFFSET 600
// Period reduction per microsecond tick
`define STEP_SPEEDUP (`STEP_VRISE / `STEP_TRISE)

`endif
